// ==== verilog/sha512_defs.svh ====
// SHA-512 sizes and counts
`ifndef SHA512_DEFS_SVH
`define SHA512_DEFS_SVH

// Word and block geometry.
`define SHA512_WORD_W 64
`define SHA512_BLOCK_W 1024
`define SHA512_HALF_W 512

// Compression loop.
`define SHA512_ROUNDS 80

// Message schedule window depth.
`define SHA512_SCHED_WORDS 16

`endif

// ==== verilog/sha512_pkg.sv ====
// SHA-512 shared types
`default_nettype none

`include "sha512_defs.svh"

package sha512_pkg;

  typedef logic [`SHA512_WORD_W-1:0] word_t;

  typedef logic [$clog2(`SHA512_ROUNDS)-1:0] round_idx_t; // 7 bits for 80 rounds.

  // Word a sits in the top bits, so the packed value is the digest in byte order.
  typedef struct packed {
    word_t a;
    word_t b;
    word_t c;
    word_t d;
    word_t e;
    word_t f;
    word_t g;
    word_t h;
  } hash_state_t;

  typedef enum logic [1:0] {
    CORE_IDLE,
    CORE_ROUNDS,
    CORE_UPDATE
  } core_state_e;

  typedef struct packed {
    logic [`SHA512_HALF_W-1:0] block;
    logic                      block_valid;
  } hash_in_t;

  typedef struct packed {
    logic [`SHA512_HALF_W-1:0] digest;
    logic                      digest_valid;
    logic                      ready;
  } hash_out_t;

  // Rotate right for all sigma functions.
  function automatic word_t rotr(word_t x, int unsigned n);
    return (x >> n) | (x << (`SHA512_WORD_W - n));
  endfunction

endpackage : sha512_pkg

`default_nettype wire

// ==== verilog/sha512_k_rom.sv ====
// SHA-512 round constants
`timescale 1ns/1ns
`default_nettype none

`include "sha512_defs.svh"

module sha512_k_rom (
  input  sha512_pkg::round_idx_t round,
  output sha512_pkg::word_t      k
);

  always_comb begin
    case (round)
      7'd0:  k = 64'h428a2f98d728ae22;
      7'd1:  k = 64'h7137449123ef65cd;
      7'd2:  k = 64'hb5c0fbcfec4d3b2f;
      7'd3:  k = 64'he9b5dba58189dbbc;
      7'd4:  k = 64'h3956c25bf348b538;
      7'd5:  k = 64'h59f111f1b605d019;
      7'd6:  k = 64'h923f82a4af194f9b;
      7'd7:  k = 64'hab1c5ed5da6d8118;
      7'd8:  k = 64'hd807aa98a3030242;
      7'd9:  k = 64'h12835b0145706fbe;
      7'd10: k = 64'h243185be4ee4b28c;
      7'd11: k = 64'h550c7dc3d5ffb4e2;
      7'd12: k = 64'h72be5d74f27b896f;
      7'd13: k = 64'h80deb1fe3b1696b1;
      7'd14: k = 64'h9bdc06a725c71235;
      7'd15: k = 64'hc19bf174cf692694;
      7'd16: k = 64'he49b69c19ef14ad2;
      7'd17: k = 64'hefbe4786384f25e3;
      7'd18: k = 64'h0fc19dc68b8cd5b5;
      7'd19: k = 64'h240ca1cc77ac9c65;
      7'd20: k = 64'h2de92c6f592b0275;
      7'd21: k = 64'h4a7484aa6ea6e483;
      7'd22: k = 64'h5cb0a9dcbd41fbd4;
      7'd23: k = 64'h76f988da831153b5;
      7'd24: k = 64'h983e5152ee66dfab;
      7'd25: k = 64'ha831c66d2db43210;
      7'd26: k = 64'hb00327c898fb213f;
      7'd27: k = 64'hbf597fc7beef0ee4;
      7'd28: k = 64'hc6e00bf33da88fc2;
      7'd29: k = 64'hd5a79147930aa725;
      7'd30: k = 64'h06ca6351e003826f;
      7'd31: k = 64'h142929670a0e6e70;
      7'd32: k = 64'h27b70a8546d22ffc;
      7'd33: k = 64'h2e1b21385c26c926;
      7'd34: k = 64'h4d2c6dfc5ac42aed;
      7'd35: k = 64'h53380d139d95b3df;
      7'd36: k = 64'h650a73548baf63de;
      7'd37: k = 64'h766a0abb3c77b2a8;
      7'd38: k = 64'h81c2c92e47edaee6;
      7'd39: k = 64'h92722c851482353b;
      7'd40: k = 64'ha2bfe8a14cf10364;
      7'd41: k = 64'ha81a664bbc423001;
      7'd42: k = 64'hc24b8b70d0f89791;
      7'd43: k = 64'hc76c51a30654be30;
      7'd44: k = 64'hd192e819d6ef5218;
      7'd45: k = 64'hd69906245565a910;
      7'd46: k = 64'hf40e35855771202a;
      7'd47: k = 64'h106aa07032bbd1b8;
      7'd48: k = 64'h19a4c116b8d2d0c8;
      7'd49: k = 64'h1e376c085141ab53;
      7'd50: k = 64'h2748774cdf8eeb99;
      7'd51: k = 64'h34b0bcb5e19b48a8;
      7'd52: k = 64'h391c0cb3c5c95a63;
      7'd53: k = 64'h4ed8aa4ae3418acb;
      7'd54: k = 64'h5b9cca4f7763e373;
      7'd55: k = 64'h682e6ff3d6b2b8a3;
      7'd56: k = 64'h748f82ee5defb2fc;
      7'd57: k = 64'h78a5636f43172f60;
      7'd58: k = 64'h84c87814a1f0ab72;
      7'd59: k = 64'h8cc702081a6439ec;
      7'd60: k = 64'h90befffa23631e28;
      7'd61: k = 64'ha4506cebde82bde9;
      7'd62: k = 64'hbef9a3f7b2c67915;
      7'd63: k = 64'hc67178f2e372532b;
      7'd64: k = 64'hca273eceea26619c;
      7'd65: k = 64'hd186b8c721c0c207;
      7'd66: k = 64'heada7dd6cde0eb1e;
      7'd67: k = 64'hf57d4f7fee6ed178;
      7'd68: k = 64'h06f067aa72176fba;
      7'd69: k = 64'h0a637dc5a2c898a6;
      7'd70: k = 64'h113f9804bef90dae;
      7'd71: k = 64'h1b710b35131c471b;
      7'd72: k = 64'h28db77f523047d84;
      7'd73: k = 64'h32caab7b40c72493;
      7'd74: k = 64'h3c9ebe0a15c9bebc;
      7'd75: k = 64'h431d67c49c100d4c;
      7'd76: k = 64'h4cc5d4becb3e42b6;
      7'd77: k = 64'h597f299cfc657e2a;
      7'd78: k = 64'h5fcb6fab3ad6faec;
      7'd79: k = 64'h6c44198c4a475817;
      default: k = '0; // Indices above 79 are never reached.
    endcase
  end

endmodule : sha512_k_rom

`default_nettype wire

// ==== verilog/sha512_schedule.sv ====
// SHA-512 message schedule
`timescale 1ns/1ns
`default_nettype none

`include "sha512_defs.svh"

module sha512_schedule (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       load,
  input  logic                       step,
  input  logic [`SHA512_BLOCK_W-1:0] block,
  output sha512_pkg::word_t          w
);

  // window[j] holds W[t-16+j] while W[t] is being formed.
  sha512_pkg::word_t window [`SHA512_SCHED_WORDS];
  sha512_pkg::word_t w_new;

  function automatic sha512_pkg::word_t small_sigma0(sha512_pkg::word_t x);
    return sha512_pkg::rotr(x, 1) ^ sha512_pkg::rotr(x, 8) ^ (x >> 7);
  endfunction

  function automatic sha512_pkg::word_t small_sigma1(sha512_pkg::word_t x);
    return sha512_pkg::rotr(x, 19) ^ sha512_pkg::rotr(x, 61) ^ (x >> 6);
  endfunction

  // W[t] = s1(W[t-2]) + W[t-7] + s0(W[t-15]) + W[t-16].
  assign w_new = small_sigma1(window[14]) + window[9] +
                 small_sigma0(window[1]) + window[0];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `SHA512_SCHED_WORDS; i++) begin
        window[i] <= '0;
      end
    end
    else if (load) begin
      // Word 0 is the most significant word of the block.
      for (int i = 0; i < `SHA512_SCHED_WORDS; i++) begin
        window[i] <= block[`SHA512_BLOCK_W-1-i*`SHA512_WORD_W -: `SHA512_WORD_W];
      end
    end
    else if (step) begin
      for (int i = 0; i < `SHA512_SCHED_WORDS-1; i++) begin
        window[i] <= window[i+1];
      end
      window[`SHA512_SCHED_WORDS-1] <= w_new;
    end
  end

  assign w = window[0]; // Oldest word.

endmodule : sha512_schedule

`default_nettype wire

// ==== verilog/sha512_core.sv ====
// SHA-512 compression core
`timescale 1ns/1ns
`default_nettype none

`include "sha512_defs.svh"

module sha512_core (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       init,
  input  logic                       next,
  input  logic [`SHA512_BLOCK_W-1:0] block,
  output logic [`SHA512_HALF_W-1:0]  digest,
  output logic                       digest_valid,
  output logic                       ready
);

  localparam sha512_pkg::hash_state_t IV = '{
    a: 64'h6a09e667f3bcc908,
    b: 64'hbb67ae8584caa73b,
    c: 64'h3c6ef372fe94f82b,
    d: 64'ha54ff53a5f1d36f1,
    e: 64'h510e527fade682d1,
    f: 64'h9b05688c2b3e6c1f,
    g: 64'h1f83d9abfb41bd6b,
    h: 64'h5be0cd19137e2179
  };

  sha512_pkg::core_state_e state;
  sha512_pkg::round_idx_t  round;
  sha512_pkg::hash_state_t wv;      // Working variables.
  sha512_pkg::hash_state_t h_reg;   // Chaining value.
  sha512_pkg::word_t       k;
  sha512_pkg::word_t       w;
  logic                    start;
  logic                    step;

  function automatic sha512_pkg::hash_state_t round_step(sha512_pkg::hash_state_t s,
                                                         sha512_pkg::word_t kt,
                                                         sha512_pkg::word_t wt);
    sha512_pkg::word_t t1;
    sha512_pkg::word_t t2;
    sha512_pkg::hash_state_t r;
    t1 = s.h + (sha512_pkg::rotr(s.e, 14) ^ sha512_pkg::rotr(s.e, 18) ^
                sha512_pkg::rotr(s.e, 41)) +
         ((s.e & s.f) ^ (~s.e & s.g)) + kt + wt;
    t2 = (sha512_pkg::rotr(s.a, 28) ^ sha512_pkg::rotr(s.a, 34) ^
          sha512_pkg::rotr(s.a, 39)) +
         ((s.a & s.b) ^ (s.a & s.c) ^ (s.b & s.c));
    r = '{a: t1 + t2, b: s.a, c: s.b, d: s.c, e: s.d + t1, f: s.e, g: s.f, h: s.g};
    return r;
  endfunction

  sha512_k_rom u_k_rom (
    .round (round),
    .k     (k)
  );

  sha512_schedule u_schedule (
    .clk   (clk),
    .reset (reset),
    .load  (start),
    .step  (step),
    .block (block),
    .w     (w)
  );

  assign start = (state == sha512_pkg::CORE_IDLE) && (init || next);
  assign step  = (state == sha512_pkg::CORE_ROUNDS);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state        <= sha512_pkg::CORE_IDLE;
      round        <= '0;
      ready        <= 1'b1;
      digest_valid <= 1'b0;
    end
    else begin
      case (state)
        sha512_pkg::CORE_IDLE: begin
          if (start) begin
            state        <= sha512_pkg::CORE_ROUNDS;
            round        <= '0;
            ready        <= 1'b0;
            digest_valid <= 1'b0;
          end
        end
        sha512_pkg::CORE_ROUNDS: begin
          if (round == `SHA512_ROUNDS - 1) begin
            state <= sha512_pkg::CORE_UPDATE;
          end
          else begin
            round <= round + 1'b1;
          end
        end
        default: begin // One update cycle.
          state        <= sha512_pkg::CORE_IDLE;
          ready        <= 1'b1;
          digest_valid <= 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      wv <= init ? IV : h_reg;
      if (init) begin
        h_reg <= IV; // New message.
      end
    end
    else if (step) begin
      wv <= round_step(wv, k, w);
    end
    else if (state == sha512_pkg::CORE_UPDATE) begin
      h_reg.a <= h_reg.a + wv.a;
      h_reg.b <= h_reg.b + wv.b;
      h_reg.c <= h_reg.c + wv.c;
      h_reg.d <= h_reg.d + wv.d;
      h_reg.e <= h_reg.e + wv.e;
      h_reg.f <= h_reg.f + wv.f;
      h_reg.g <= h_reg.g + wv.g;
      h_reg.h <= h_reg.h + wv.h;
    end
  end

  assign digest = h_reg;

  a_round_range: assert property (@(posedge clk) disable iff (reset)
    round < `SHA512_ROUNDS);

  // Only the idle time after reset has ready without digest_valid.
  a_valid_ready: assert property (@(posedge clk) disable iff (reset)
    (digest_valid || state != sha512_pkg::CORE_IDLE) |-> (digest_valid == ready));

endmodule : sha512_core

`default_nettype wire

// ==== verilog/sha512.sv ====
// SHA-512 half-block front end
`timescale 1ns/1ns
`default_nettype none

`include "sha512_defs.svh"

module sha512 (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [`SHA512_HALF_W-1:0] block,
  input  logic                      block_valid,
  output logic [`SHA512_HALF_W-1:0] digest,
  output logic                      digest_valid,
  output logic                      ready
);

  logic                       init;
  logic                       next;
  logic                       ptr;          // High when the next strobe is the upper half.
  logic                       first_time;
  logic [`SHA512_BLOCK_W-1:0] local_block;

  sha512_core u_sha512_core (
    .clk          (clk),
    .reset        (reset),
    .init         (init),
    .next         (next),
    .block        (local_block),
    .digest       (digest),
    .digest_valid (digest_valid),
    .ready        (ready)
  );

  always_ff @(posedge clk) begin
    if (block_valid) begin
      if (ptr) begin
        local_block[`SHA512_BLOCK_W-1:`SHA512_HALF_W] <= block;
      end
      else begin
        local_block[`SHA512_HALF_W-1:0] <= block;
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ptr        <= 1'b0;
      first_time <= 1'b1;
      init       <= 1'b0;
      next       <= 1'b0;
    end
    else begin
      if (block_valid) begin
        ptr <= !ptr;
      end
      if (block_valid && ptr) begin
        first_time <= 1'b0; // Later blocks chain.
      end
      init <= block_valid && ptr && first_time;
      next <= block_valid && ptr && !first_time;
    end
  end

  a_no_strobe_busy: assert property (@(posedge clk) disable iff (reset)
    block_valid |-> ready);

  a_init_next_excl: assert property (@(posedge clk) disable iff (reset)
    !(init && next));

endmodule : sha512

`default_nettype wire

// ==== verilog/sha512_top.sv ====
// SHA-512 top level
`timescale 1ns/1ns
`default_nettype none

`include "sha512_defs.svh"

module sha512_top (
  input  logic                  clk,
  input  logic                  reset,
  input  sha512_pkg::hash_in_t  in,
  output sha512_pkg::hash_out_t out
);

  logic [`SHA512_HALF_W-1:0] digest;
  logic                      digest_valid;
  logic                      ready;

  sha512 u_sha512 (
    .clk          (clk),
    .reset        (reset),
    .block        (in.block),
    .block_valid  (in.block_valid),
    .digest       (digest),
    .digest_valid (digest_valid),
    .ready        (ready)
  );

  assign out = '{digest: digest, digest_valid: digest_valid, ready: ready};

endmodule : sha512_top

`default_nettype wire

// ==== verification/sha512_model.sv ====
// SHA-512 reference model
`default_nettype none

`include "sha512_defs.svh"

package sha512_model;

  typedef logic [`SHA512_WORD_W-1:0] word64_t;

  localparam logic [`SHA512_HALF_W-1:0] IV = {
    64'h6a09e667f3bcc908, 64'hbb67ae8584caa73b, 64'h3c6ef372fe94f82b, 64'ha54ff53a5f1d36f1,
    64'h510e527fade682d1, 64'h9b05688c2b3e6c1f, 64'h1f83d9abfb41bd6b, 64'h5be0cd19137e2179};

  // Round constants with K[0] leftmost.
  localparam logic [0:`SHA512_ROUNDS-1][`SHA512_WORD_W-1:0] K = {
    64'h428a2f98d728ae22, 64'h7137449123ef65cd, 64'hb5c0fbcfec4d3b2f, 64'he9b5dba58189dbbc,
    64'h3956c25bf348b538, 64'h59f111f1b605d019, 64'h923f82a4af194f9b, 64'hab1c5ed5da6d8118,
    64'hd807aa98a3030242, 64'h12835b0145706fbe, 64'h243185be4ee4b28c, 64'h550c7dc3d5ffb4e2,
    64'h72be5d74f27b896f, 64'h80deb1fe3b1696b1, 64'h9bdc06a725c71235, 64'hc19bf174cf692694,
    64'he49b69c19ef14ad2, 64'hefbe4786384f25e3, 64'h0fc19dc68b8cd5b5, 64'h240ca1cc77ac9c65,
    64'h2de92c6f592b0275, 64'h4a7484aa6ea6e483, 64'h5cb0a9dcbd41fbd4, 64'h76f988da831153b5,
    64'h983e5152ee66dfab, 64'ha831c66d2db43210, 64'hb00327c898fb213f, 64'hbf597fc7beef0ee4,
    64'hc6e00bf33da88fc2, 64'hd5a79147930aa725, 64'h06ca6351e003826f, 64'h142929670a0e6e70,
    64'h27b70a8546d22ffc, 64'h2e1b21385c26c926, 64'h4d2c6dfc5ac42aed, 64'h53380d139d95b3df,
    64'h650a73548baf63de, 64'h766a0abb3c77b2a8, 64'h81c2c92e47edaee6, 64'h92722c851482353b,
    64'ha2bfe8a14cf10364, 64'ha81a664bbc423001, 64'hc24b8b70d0f89791, 64'hc76c51a30654be30,
    64'hd192e819d6ef5218, 64'hd69906245565a910, 64'hf40e35855771202a, 64'h106aa07032bbd1b8,
    64'h19a4c116b8d2d0c8, 64'h1e376c085141ab53, 64'h2748774cdf8eeb99, 64'h34b0bcb5e19b48a8,
    64'h391c0cb3c5c95a63, 64'h4ed8aa4ae3418acb, 64'h5b9cca4f7763e373, 64'h682e6ff3d6b2b8a3,
    64'h748f82ee5defb2fc, 64'h78a5636f43172f60, 64'h84c87814a1f0ab72, 64'h8cc702081a6439ec,
    64'h90befffa23631e28, 64'ha4506cebde82bde9, 64'hbef9a3f7b2c67915, 64'hc67178f2e372532b,
    64'hca273eceea26619c, 64'hd186b8c721c0c207, 64'heada7dd6cde0eb1e, 64'hf57d4f7fee6ed178,
    64'h06f067aa72176fba, 64'h0a637dc5a2c898a6, 64'h113f9804bef90dae, 64'h1b710b35131c471b,
    64'h28db77f523047d84, 64'h32caab7b40c72493, 64'h3c9ebe0a15c9bebc, 64'h431d67c49c100d4c,
    64'h4cc5d4becb3e42b6, 64'h597f299cfc657e2a, 64'h5fcb6fab3ad6faec, 64'h6c44198c4a475817};

  function automatic word64_t ror64(word64_t x, int n);
    return (x >> n) | (x << (`SHA512_WORD_W - n));
  endfunction

  // One compression. Chaining value in, next chaining value out.
  function automatic logic [`SHA512_HALF_W-1:0] compress(logic [`SHA512_HALF_W-1:0] hin,
                                                         logic [`SHA512_BLOCK_W-1:0] blk);
    word64_t w [`SHA512_ROUNDS];
    word64_t v [8];
    word64_t t1;
    word64_t t2;
    logic [`SHA512_HALF_W-1:0] hout;
    for (int t = 0; t < 16; t++) begin
      w[t] = blk[`SHA512_BLOCK_W-1-`SHA512_WORD_W*t -: `SHA512_WORD_W];
    end
    for (int t = 16; t < `SHA512_ROUNDS; t++) begin
      w[t] = (ror64(w[t-2], 19) ^ ror64(w[t-2], 61) ^ (w[t-2] >> 6)) + w[t-7] +
             (ror64(w[t-15], 1) ^ ror64(w[t-15], 8) ^ (w[t-15] >> 7)) + w[t-16];
    end
    for (int i = 0; i < 8; i++) begin
      v[i] = hin[`SHA512_HALF_W-1-`SHA512_WORD_W*i -: `SHA512_WORD_W];
    end
    for (int t = 0; t < `SHA512_ROUNDS; t++) begin
      t1 = v[7] + (ror64(v[4], 14) ^ ror64(v[4], 18) ^ ror64(v[4], 41)) +
           ((v[4] & v[5]) ^ (~v[4] & v[6])) + K[t] + w[t];
      t2 = (ror64(v[0], 28) ^ ror64(v[0], 34) ^ ror64(v[0], 39)) +
           ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
      for (int i = 7; i > 0; i--) begin
        v[i] = v[i-1];
      end
      v[4] = v[4] + t1; // Old d plus t1.
      v[0] = t1 + t2;
    end
    for (int i = 0; i < 8; i++) begin
      hout[`SHA512_HALF_W-1-`SHA512_WORD_W*i -: `SHA512_WORD_W] =
          hin[`SHA512_HALF_W-1-`SHA512_WORD_W*i -: `SHA512_WORD_W] + v[i];
    end
    return hout;
  endfunction

endpackage : sha512_model

`default_nettype wire

// ==== verification/sha512_tb.sv ====
// SHA-512 testbench
`timescale 1ns/1ns
`default_nettype none

`include "sha512_defs.svh"

module sha512_tb;

  localparam int NUM_BLOCKS      = 6;
  localparam int WATCHDOG_CYCLES = NUM_BLOCKS * 100 + 200;
  localparam int LATENCY         = 82; // Edges from second half to digest_valid.

  // Published digest of "abc".
  localparam logic [`SHA512_HALF_W-1:0] ABC_DIGEST = {
    64'hddaf35a193617aba, 64'hcc417349ae204131, 64'h12e6fa4e89a97ea2, 64'h0a9eeee64b55d39a,
    64'h2192992a274fc1a8, 64'h36ba3c23a3feebbd, 64'h454d4423643ce80e, 64'h2a9ac94fa54ca49f};

  logic                       clk;
  logic                       reset;
  sha512_pkg::hash_in_t       in;
  sha512_pkg::hash_out_t      out;
  logic [`SHA512_HALF_W-1:0]  exp_digest;
  logic [`SHA512_HALF_W-1:0]  chain;
  logic [`SHA512_BLOCK_W-1:0] blk;
  logic                       high_half;      // Strobe carries bits 1023:512.
  logic                       idle_expected;
  logic                       check_published;
  logic [7:0]                 edge_cnt;
  string                      test_name;
  integer                     seed;
  int                         value_errors;
  int                         timeouts;

  sha512_top uut (.clk(clk), .reset(reset), .in(in), .out(out));

  always #50 clk = ~clk;

  // Saturating count of edges since the second half was sampled.
  always @(posedge clk or posedge reset) begin
    if (reset) begin
      edge_cnt <= 8'hff;
    end
    else if (in.block_valid && high_half) begin
      edge_cnt <= '0;
    end
    else if (edge_cnt != 8'hff) begin
      edge_cnt <= edge_cnt + 8'd1;
    end
  end

  a_idle: assert property (@(posedge clk) disable iff (reset)
    idle_expected |-> (out.ready && !out.digest_valid))
    else begin
      value_errors++;
      $display("ERR %s idle: expected ready=1 digest_valid=0, actual ready=%0b digest_valid=%0b",
               test_name, $sampled(out.ready), $sampled(out.digest_valid));
    end

  a_busy: assert property (@(posedge clk) disable iff (reset)
    (edge_cnt >= 1 && edge_cnt < LATENCY) |-> (!out.ready && !out.digest_valid))
    else begin
      value_errors++;
      $display("ERR %s busy: expected ready=0 digest_valid=0, actual ready=%0b digest_valid=%0b",
               test_name, $sampled(out.ready), $sampled(out.digest_valid));
    end

  a_latency: assert property (@(posedge clk) disable iff (reset)
    $rose(out.digest_valid) |-> (edge_cnt == LATENCY))
    else begin
      value_errors++;
      $display("ERR %s latency: expected %0d actual %0d", test_name, LATENCY,
               $sampled(edge_cnt));
    end

  a_digest: assert property (@(posedge clk) disable iff (reset)
    $rose(out.digest_valid) |-> (out.digest == exp_digest))
    else begin
      value_errors++;
      $display("ERR %s digest: expected %h actual %h", test_name, exp_digest,
               $sampled(out.digest));
    end

  a_published: assert property (@(posedge clk) disable iff (reset)
    ($rose(out.digest_valid) && check_published) |-> (out.digest == ABC_DIGEST))
    else begin
      value_errors++;
      $display("ERR %s published: expected %h actual %h", test_name, ABC_DIGEST,
               $sampled(out.digest));
    end

  task automatic apply_reset();
    reset         = 1'b1;
    idle_expected = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset         = 1'b0;
    idle_expected = 1'b1;
  endtask

  task automatic strobe_half(input logic [`SHA512_HALF_W-1:0] half, input logic upper);
    in.block       = half;
    in.block_valid = 1'b1;
    high_half      = upper;
    idle_expected  = 1'b0;
    @(negedge clk);
    in.block_valid = 1'b0;
    high_half      = 1'b0;
  endtask

  // Sends one block with a random gap between halves and waits for its digest.
  task automatic send_block(input logic [`SHA512_BLOCK_W-1:0] b, input logic first);
    int gap;
    int n;
    if (first) begin
      chain = sha512_model::IV;
    end
    exp_digest = sha512_model::compress(chain, b);
    chain      = exp_digest;
    gap        = {$random(seed)} % 8;
    strobe_half(b[`SHA512_HALF_W-1:0], 1'b0);
    repeat (gap) @(negedge clk);
    strobe_half(b[`SHA512_BLOCK_W-1:`SHA512_HALF_W], 1'b1);
    @(negedge clk);
    n = 0;
    while (!out.digest_valid && n < 2 * LATENCY) begin
      @(negedge clk);
      n++;
    end
    if (!out.digest_valid) begin
      timeouts++;
      $display("Timeout in %s: no digest_valid within %0d cycles", test_name, n);
    end
    @(negedge clk); // Let the digest checks sample.
  endtask

  task automatic fill_random(output logic [`SHA512_BLOCK_W-1:0] b);
    for (int i = 0; i < `SHA512_BLOCK_W / 32; i++) begin
      b[32*i +: 32] = $random(seed);
    end
  endtask

  initial begin
    clk             = 1'b0;
    reset           = 1'b1;
    in              = '0;
    high_half       = 1'b0;
    idle_expected   = 1'b0;
    check_published = 1'b0;
    exp_digest      = '0;
    chain           = '0;
    blk             = '0;
    value_errors    = 0;
    timeouts        = 0;
    seed            = 32'h1bf5_8e90;

    test_name = "reset_idle";
    apply_reset();
    repeat (5) @(negedge clk);

    test_name = "abc_block";
    blk = '0;
    blk[`SHA512_BLOCK_W-1 -: 32] = 32'h6162_6380; // "abc" and the pad bit.
    blk[127:0] = 128'd24;
    check_published = 1'b1;
    send_block(blk, 1'b1);

    // 896-bit message "abcdefgh" "bcdefghi" ... "nopqrstu" needs two blocks.
    test_name = "two_block";
    apply_reset();
    check_published = 1'b0;
    blk = '0;
    for (int i = 0; i < 14; i++) begin
      for (int j = 0; j < 8; j++) begin
        blk[`SHA512_BLOCK_W-1-8*(8*i+j) -: 8] = 8'h61 + 8'(i + j);
      end
    end
    blk[`SHA512_BLOCK_W-1-8*112 -: 8] = 8'h80;
    send_block(blk, 1'b1);
    blk = '0;
    blk[127:0] = 128'd896; // Length only.
    send_block(blk, 1'b0);

    test_name = "random_gaps";
    apply_reset();
    for (int b = 0; b < NUM_BLOCKS - 3; b++) begin
      fill_random(blk);
      send_block(blk, b == 0);
    end

    $display("Errors: %0d value mismatches, %0d timeouts", value_errors, timeouts);
    if (value_errors == 0 && timeouts == 0) begin
      $display("Test completed successfully");
    end
    else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule : sha512_tb

`default_nettype wire

// ==== build.f ====
+incdir+verilog
verilog/sha512_pkg.sv
verilog/sha512_k_rom.sv
verilog/sha512_schedule.sv
verilog/sha512_core.sv
verilog/sha512.sv
verilog/sha512_top.sv
verification/sha512_model.sv
verification/sha512_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module sha512_tb -f build.f \
  -o sha512_sim && ./obj_dir/sha512_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Test completed successfully" sim.log && echo "Simulation passed" || {
  echo "Simulation failed"
  exit 1
}
